// ==== dv/csr_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_tb;

  import csr_pkg::*;

  // The tests take roughly 330 cycles
  localparam int CYCLE_LIMIT = 2000;
  localparam logic [`CSR_XLEN-1:0] HART_ID = 64'h0000_0000_0000_0005;

  logic                  clk;
  logic                  rst;
  logic                  cmd_v;
  csr_op_e               cmd_op;
  logic [11:0]           cmd_addr;
  logic [`CSR_XLEN-1:0]  cmd_wdata;
  logic                  ret_v;
  logic [`CSR_XLEN-1:0]  ret_pc;
  logic [31:0]           ret_instr;
  logic [`CSR_XLEN-1:0]  ret_vaddr;
  logic [`EXC_WIDTH-1:0] ret_exc;
  logic                  ret_irq;
  logic                  ret_mret;
  logic                  timer_irq;
  logic                  sw_irq;
  logic                  ext_irq;

  logic                  csr_v;
  logic [`CSR_XLEN-1:0]  csr_data;
  logic                  csr_illegal;
  logic                  commit_v;
  logic                  redirect;
  logic                  trap;
  logic [`CSR_XLEN-1:0]  npc;
  logic                  irq_pending;
  logic [1:0]            priv;

  int    seed = 57012;
  int    err_cnt;
  int    check_cnt;
  int    cycle_cnt;
  string test_name;

  // Reference copies of the machine CSRs
  logic [`CSR_XLEN-1:0] mstatus_ref, mtvec_ref, mscratch_ref, mepc_ref;
  logic [`CSR_XLEN-1:0] mcause_ref, mtval_ref, mie_ref;
  logic [1:0]           priv_ref;

  csr_top uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .hart_id_i      (HART_ID),
    .csr_cmd_v_i    (cmd_v),
    .csr_op_i       (cmd_op),
    .csr_addr_i     (cmd_addr),
    .csr_wdata_i    (cmd_wdata),
    .retire_v_i     (ret_v),
    .retire_pc_i    (ret_pc),
    .retire_instr_i (ret_instr),
    .retire_vaddr_i (ret_vaddr),
    .retire_exc_i   (ret_exc),
    .retire_irq_i   (ret_irq),
    .retire_mret_i  (ret_mret),
    .timer_irq_i    (timer_irq),
    .software_irq_i (sw_irq),
    .external_irq_i (ext_irq),
    .csr_v_o        (csr_v),
    .csr_data_o     (csr_data),
    .csr_illegal_o  (csr_illegal),
    .commit_v_o     (commit_v),
    .redirect_o     (redirect),
    .trap_o         (trap),
    .npc_o          (npc),
    .irq_pending_o  (irq_pending),
    .priv_o         (priv)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles, a test never finished", cycle_cnt);
    $display("Regression failed");
    $finish;
  end

  task automatic check_eq(input string what, input logic [`CSR_XLEN-1:0] exp,
                          input logic [`CSR_XLEN-1:0] act);
    check_cnt++;
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_eq(what, {63'd0, exp}, {63'd0, act});
  endtask

  function automatic logic [`CSR_XLEN-1:0] rmw_result(input csr_op_e op,
                                                     input logic [`CSR_XLEN-1:0] old,
                                                     input logic [`CSR_XLEN-1:0] src);
    logic [`CSR_XLEN-1:0] opnd;
    opnd = src;
    // zimm is the low five bits, zero-extended
    if (op == e_csrrwi || op == e_csrrsi || op == e_csrrci)
      opnd = {59'd0, src[4:0]};
    case (op)
      e_csrrw, e_csrrwi: return opnd;
      e_csrrs, e_csrrsi: return old | opnd;
      e_csrrc, e_csrrci: return old & ~opnd;
      default:           return old;
    endcase
  endfunction

  function automatic logic [3:0] lowest_code(input logic [`EXC_WIDTH-1:0] exc);
    for (int i = 0; i < `EXC_WIDTH; i++)
    begin
      if (exc[i])
        return 4'(i);
    end
    return 4'd0;
  endfunction

  // mpp takes the old privilege, mpie the old mie
  function automatic logic [`CSR_XLEN-1:0] status_on_trap(input logic [`CSR_XLEN-1:0] s,
                                                         input logic [1:0] from_priv);
    logic [`CSR_XLEN-1:0] n;
    n        = s;
    n[12:11] = from_priv;
    n[7]     = s[3];
    n[3]     = 1'b0;
    return n;
  endfunction

  task automatic csr_access(input csr_op_e op, input logic [11:0] addr,
                            input logic [`CSR_XLEN-1:0] wdata,
                            output logic [`CSR_XLEN-1:0] data, output logic ill);
    @(posedge clk);
    #1;
    cmd_v     = 1'b1;
    cmd_op    = op;
    cmd_addr  = addr;
    cmd_wdata = wdata;
    @(posedge clk);
    #1;
    cmd_v = 1'b0;
    @(negedge clk);
    check_bit("csr_v", 1'b1, csr_v);
    data = csr_data;
    ill  = csr_illegal;
    // Write lands on this edge
    @(posedge clk);
    #1;
  endtask

  task automatic csr_expect(input csr_op_e op, input logic [11:0] addr,
                            input logic [`CSR_XLEN-1:0] wdata,
                            input logic [`CSR_XLEN-1:0] exp_data, input logic exp_ill);
    logic [`CSR_XLEN-1:0] data;
    logic                 ill;
    csr_access(op, addr, wdata, data, ill);
    check_bit($sformatf("csr %h illegal", addr), exp_ill, ill);
    if (!exp_ill)
      check_eq($sformatf("csr %h data", addr), exp_data, data);
  endtask

  task automatic retire_expect(input logic [`CSR_XLEN-1:0] pc, input logic [31:0] instr,
                               input logic [`CSR_XLEN-1:0] vaddr,
                               input logic [`EXC_WIDTH-1:0] exc,
                               input logic irq, input logic mret,
                               input logic exp_redirect, input logic exp_trap,
                               input logic [`CSR_XLEN-1:0] exp_npc);
    @(posedge clk);
    #1;
    ret_v     = 1'b1;
    ret_pc    = pc;
    ret_instr = instr;
    ret_vaddr = vaddr;
    ret_exc   = exc;
    ret_irq   = irq;
    ret_mret  = mret;
    @(posedge clk);
    #1;
    ret_v    = 1'b0;
    ret_exc  = '0;
    ret_irq  = 1'b0;
    ret_mret = 1'b0;
    @(negedge clk);
    check_bit("commit_v", 1'b1, commit_v);
    check_bit("redirect", exp_redirect, redirect);
    check_bit("trap", exp_trap, trap);
    check_eq("npc", exp_npc, npc);
    @(posedge clk);
    #1;
  endtask

  task automatic drive_irq(input logic t, input logic s, input logic e);
    @(posedge clk);
    #1;
    timer_irq = t;
    sw_irq    = s;
    ext_irq   = e;
    // mip samples the lines one cycle late
    @(posedge clk);
    #1;
  endtask

  task automatic check_trap_state();
    csr_expect(e_csrr, `CSR_ADDR_MCAUSE, '0, mcause_ref, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MEPC, '0, mepc_ref, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MTVAL, '0, mtval_ref, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MSTATUS, '0, mstatus_ref, 1'b0);
    check_eq("priv", {62'd0, priv_ref}, {62'd0, priv});
  endtask

  initial
  begin
    csr_op_e              rmw_ops [6];
    csr_op_e              op;
    int                   idx;
    logic [31:0]          rnd;
    logic [`CSR_XLEN-1:0] operand;
    logic [`CSR_XLEN-1:0] pc;
    logic [`CSR_XLEN-1:0] vaddr;
    logic [`EXC_WIDTH-1:0] exc;
    logic [3:0]           code;
    logic [`CSR_XLEN-1:0] data;
    logic [`CSR_XLEN-1:0] first;
    logic                 ill;

    rmw_ops   = '{e_csrrw, e_csrrs, e_csrrc, e_csrrwi, e_csrrsi, e_csrrci};
    err_cnt   = 0;
    check_cnt = 0;
    test_name = "reset";
    rst       = 1'b1;
    cmd_v     = 1'b0;
    cmd_op    = e_csrr;
    cmd_addr  = '0;
    cmd_wdata = '0;
    ret_v     = 1'b0;
    ret_pc    = '0;
    ret_instr = '0;
    ret_vaddr = '0;
    ret_exc   = '0;
    ret_irq   = 1'b0;
    ret_mret  = 1'b0;
    timer_irq = 1'b0;
    sw_irq    = 1'b0;
    ext_irq   = 1'b0;

    mstatus_ref  = '0;
    mtvec_ref    = '0;
    mscratch_ref = '0;
    mepc_ref     = '0;
    mcause_ref   = '0;
    mtval_ref    = '0;
    mie_ref      = '0;
    priv_ref     = `PRIV_M;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_bit("csr_v", 1'b0, csr_v);
    check_bit("csr_illegal", 1'b0, csr_illegal);
    check_bit("commit_v", 1'b0, commit_v);
    check_bit("redirect", 1'b0, redirect);
    check_bit("trap", 1'b0, trap);
    check_bit("irq_pending", 1'b0, irq_pending);
    check_eq("priv", {62'd0, `PRIV_M}, {62'd0, priv});

    test_name = "rmw";
    // Every form twice, each with a fresh random operand
    for (int i = 0; i < 12; i++)
    begin
      idx     = i % 6;
      op      = rmw_ops[idx];
      operand = {$random(seed), $random(seed)};
      csr_expect(op, `CSR_ADDR_MSCRATCH, operand, mscratch_ref, 1'b0);
      mscratch_ref = rmw_result(op, mscratch_ref, operand);
      csr_expect(e_csrr, `CSR_ADDR_MSCRATCH, '0, mscratch_ref, 1'b0);
    end

    test_name = "identity";
    csr_expect(e_csrr, `CSR_ADDR_MISA, '0, `MISA_VALUE, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MARCHID, '0, `MARCHID_VALUE, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MIMPID, '0, `MIMPID_VALUE, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MHARTID, '0, HART_ID, 1'b0);

    test_name = "illegal";
    operand = {$random(seed), $random(seed)};
    csr_expect(e_csrr, 12'h7c0, '0, '0, 1'b1);
    csr_expect(e_csrrw, 12'h345, operand, '0, 1'b1);
    csr_expect(e_csrrw, `CSR_ADDR_MISA, operand, '0, 1'b1);
    csr_expect(e_csrrs, `CSR_ADDR_MHARTID, operand, '0, 1'b1);
    csr_expect(e_csrr, `CSR_ADDR_MISA, '0, `MISA_VALUE, 1'b0);
    csr_expect(e_csrr, `CSR_ADDR_MSCRATCH, '0, mscratch_ref, 1'b0);

    test_name = "exception";
    operand = {$random(seed), $random(seed)};
    csr_expect(e_csrrw, `CSR_ADDR_MTVEC, operand, mtvec_ref, 1'b0);
    mtvec_ref = operand;
    for (int i = 0; i < 4; i++)
    begin
      csr_expect(e_csrrs, `CSR_ADDR_MSTATUS, 64'h8, mstatus_ref, 1'b0);
      mstatus_ref = mstatus_ref | 64'h8;
      pc    = {$random(seed), $random(seed)} & ~64'h3;
      vaddr = {$random(seed), $random(seed)};
      rnd   = $random(seed);
      exc   = rnd[15:0];
      // First pass covers the illegal-instruction tval
      if (i == 0)
        exc = (exc & 16'hfff8) | 16'h0004;
      if (exc == '0)
        exc = 16'h8000;
      rnd = $random(seed);
      retire_expect(pc, rnd, vaddr, exc, 1'b0, 1'b0, 1'b1, 1'b1,
                    {mtvec_ref[`CSR_XLEN-1:2], 2'b00});
      code        = lowest_code(exc);
      mepc_ref    = pc;
      mcause_ref  = {60'd0, code};
      mtval_ref   = (code == 4'd2) ? {32'd0, rnd} : vaddr;
      mstatus_ref = status_on_trap(mstatus_ref, priv_ref);
      priv_ref    = `PRIV_M;
      check_trap_state();
    end

    test_name = "mret";
    operand = {$random(seed), $random(seed)} & ~64'h3;
    csr_expect(e_csrrw, `CSR_ADDR_MEPC, operand, mepc_ref, 1'b0);
    mepc_ref = operand;
    csr_expect(e_csrrc, `CSR_ADDR_MSTATUS, 64'h1800, mstatus_ref, 1'b0);
    mstatus_ref = mstatus_ref & ~64'h1800;
    csr_expect(e_csrrs, `CSR_ADDR_MSTATUS, 64'h80, mstatus_ref, 1'b0);
    mstatus_ref = mstatus_ref | 64'h80;
    pc = {$random(seed), $random(seed)} & ~64'h3;
    retire_expect(pc, 32'h3020_0073, '0, '0, 1'b0, 1'b1, 1'b1, 1'b0, mepc_ref);
    priv_ref        = (mstatus_ref[12:11] == `PRIV_U) ? `PRIV_U : `PRIV_M;
    mstatus_ref[3]  = mstatus_ref[7];
    mstatus_ref[7]  = 1'b1;
    mstatus_ref[12:11] = `PRIV_U;
    check_eq("priv", {62'd0, priv_ref}, {62'd0, priv});
    csr_expect(e_csrr, `CSR_ADDR_MSCRATCH, '0, '0, 1'b1);
    csr_expect(e_csrrw, `CSR_ADDR_MSTATUS, operand, '0, 1'b1);
    // ecall from U
    pc    = {$random(seed), $random(seed)} & ~64'h3;
    vaddr = {$random(seed), $random(seed)};
    retire_expect(pc, 32'h0000_0073, vaddr, 16'h0100, 1'b0, 1'b0, 1'b1, 1'b1,
                  {mtvec_ref[`CSR_XLEN-1:2], 2'b00});
    mepc_ref    = pc;
    mcause_ref  = 64'd8;
    mtval_ref   = vaddr;
    mstatus_ref = status_on_trap(mstatus_ref, priv_ref);
    priv_ref    = `PRIV_M;
    check_trap_state();

    test_name = "interrupt";
    csr_expect(e_csrrs, `CSR_ADDR_MIE, 64'h888, mie_ref, 1'b0);
    mie_ref = mie_ref | 64'h888;
    csr_expect(e_csrrs, `CSR_ADDR_MSTATUS, 64'h8, mstatus_ref, 1'b0);
    mstatus_ref = mstatus_ref | 64'h8;
    check_bit("irq_pending idle", 1'b0, irq_pending);
    drive_irq(1'b1, 1'b0, 1'b0);
    check_bit("irq_pending timer", 1'b1, irq_pending);
    pc = {$random(seed), $random(seed)} & ~64'h3;
    retire_expect(pc, '0, '0, '0, 1'b1, 1'b0, 1'b1, 1'b1,
                  {mtvec_ref[`CSR_XLEN-1:2], 2'b00});
    mepc_ref    = pc;
    mcause_ref  = 64'h8000_0000_0000_0007;
    mtval_ref   = '0;
    mstatus_ref = status_on_trap(mstatus_ref, priv_ref);
    check_trap_state();
    check_bit("irq_pending masked", 1'b0, irq_pending);
    csr_expect(e_csrrs, `CSR_ADDR_MSTATUS, 64'h8, mstatus_ref, 1'b0);
    mstatus_ref = mstatus_ref | 64'h8;
    drive_irq(1'b1, 1'b0, 1'b1);
    check_bit("irq_pending both", 1'b1, irq_pending);
    pc = {$random(seed), $random(seed)} & ~64'h3;
    retire_expect(pc, '0, '0, '0, 1'b1, 1'b0, 1'b1, 1'b1,
                  {mtvec_ref[`CSR_XLEN-1:2], 2'b00});
    mepc_ref    = pc;
    mcause_ref  = 64'h8000_0000_0000_000b;
    mstatus_ref = status_on_trap(mstatus_ref, priv_ref);
    check_trap_state();
    drive_irq(1'b0, 1'b0, 1'b0);

    test_name = "counters";
    csr_access(e_csrr, `CSR_ADDR_MINSTRET, '0, first, ill);
    for (int i = 0; i < 5; i++)
    begin
      pc = {$random(seed), $random(seed)} & ~64'h3;
      retire_expect(pc, 32'h0000_0013, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, pc + 64'd4);
    end
    csr_access(e_csrr, `CSR_ADDR_MINSTRET, '0, data, ill);
    check_eq("minstret count", first + 64'd5, data);
    csr_expect(e_csrrs, `CSR_ADDR_MCOUNTINHIBIT, 64'h4, '0, 1'b0);
    csr_access(e_csrr, `CSR_ADDR_MINSTRET, '0, first, ill);
    for (int i = 0; i < 3; i++)
    begin
      pc = {$random(seed), $random(seed)} & ~64'h3;
      retire_expect(pc, 32'h0000_0013, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, pc + 64'd4);
    end
    csr_access(e_csrr, `CSR_ADDR_INSTRET, '0, data, ill);
    check_eq("minstret inhibited", first, data);

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_cmd_stage.sv
verilog/csr_retire_stage.sv
verilog/csr_irq_arbiter.sv
verilog/csr_regfile.sv
verilog/csr_top.sv
dv/csr_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module csr_tb \
  -f list.f -o csr_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/csr_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Regression failed" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "Regression passed" "$SIM_LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// ==== verilog/csr_cmd_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_cmd_stage (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   csr_cmd_v_i,
  input  wire csr_pkg::csr_op_e csr_op_i,
  input  wire [11:0]            csr_addr_i,
  input  wire [`CSR_XLEN-1:0]   csr_wdata_i,
  output logic                  cmd_v_o,
  output csr_pkg::csr_op_e      cmd_op_o,
  output logic [11:0]           cmd_addr_o,
  output logic [`CSR_XLEN-1:0]  cmd_operand_o
);

  import csr_pkg::*;

  logic                 is_imm;
  logic [`CSR_XLEN-1:0] operand;

  assign is_imm = csr_op_i inside {e_csrrwi, e_csrrsi, e_csrrci};

  // Immediate forms take the 5-bit zimm field, zero-extended
  assign operand = is_imm ? {{(`CSR_XLEN-5){1'b0}}, csr_wdata_i[4:0]} : csr_wdata_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cmd_v_o <= 1'b0;
    else
      cmd_v_o <= csr_cmd_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    cmd_op_o      <= csr_op_i;
    cmd_addr_o    <= csr_addr_i;
    cmd_operand_o <= operand;
  end

  a_op_defined: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_v_o |-> cmd_op_o inside {e_csrr, e_csrrw, e_csrrs, e_csrrc,
                                 e_csrrwi, e_csrrsi, e_csrrci});

endmodule

`default_nettype wire

// ==== verilog/csr_irq_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_irq_arbiter (
  input  wire [`CSR_XLEN-1:0] mie_i,
  input  wire [`CSR_XLEN-1:0] mip_i,
  input  wire                 mstatus_mie_i,
  input  wire [1:0]           priv_i,
  output logic                irq_v_o,
  output logic [3:0]          irq_code_o
);

  logic [`CSR_XLEN-1:0] pend;
  logic                 any_pend;
  logic                 gie;

  assign pend     = mie_i & mip_i;
  assign any_pend = pend[`IRQ_CODE_MEI] | pend[`IRQ_CODE_MSI] | pend[`IRQ_CODE_MTI];

  // Below M, machine interrupts are always enabled
  assign gie = (priv_i == `PRIV_U) | mstatus_mie_i;

  // External first, then software, then timer
  always_comb
  begin
    if (pend[`IRQ_CODE_MEI])
      irq_code_o = `IRQ_CODE_MEI;
    else if (pend[`IRQ_CODE_MSI])
      irq_code_o = `IRQ_CODE_MSI;
    else
      irq_code_o = `IRQ_CODE_MTI;
  end

  assign irq_v_o = any_pend & gie;

endmodule

`default_nettype wire

// ==== verilog/csr_macros.svh ====
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN 64

// Machine-level CSR addresses
`define CSR_ADDR_MSTATUS       12'h300
`define CSR_ADDR_MISA          12'h301
`define CSR_ADDR_MIE           12'h304
`define CSR_ADDR_MTVEC         12'h305
`define CSR_ADDR_MCOUNTINHIBIT 12'h320
`define CSR_ADDR_MSCRATCH      12'h340
`define CSR_ADDR_MEPC          12'h341
`define CSR_ADDR_MCAUSE        12'h342
`define CSR_ADDR_MTVAL         12'h343
`define CSR_ADDR_MIP           12'h344
`define CSR_ADDR_MCYCLE        12'hb00
`define CSR_ADDR_MINSTRET      12'hb02
`define CSR_ADDR_CYCLE         12'hc00
`define CSR_ADDR_INSTRET       12'hc02
`define CSR_ADDR_MVENDORID     12'hf11
`define CSR_ADDR_MARCHID       12'hf12
`define CSR_ADDR_MIMPID        12'hf13
`define CSR_ADDR_MHARTID       12'hf14

`define PRIV_M 2'b11
`define PRIV_U 2'b00

`define EXC_WIDTH             16
`define EXC_CODE_ILLEGAL_INSTR 4'd2

// Interrupt codes double as mie/mip bit positions
`define IRQ_CODE_MSI 4'd3
`define IRQ_CODE_MTI 4'd7
`define IRQ_CODE_MEI 4'd11

`define MCOUNTINHIBIT_CY 0
`define MCOUNTINHIBIT_IR 2

// MXL 64, extensions IMAFDSU
`define MISA_VALUE      64'h8000_0000_0014_1129
`define MVENDORID_VALUE 64'd0
`define MARCHID_VALUE   64'd13
`define MIMPID_VALUE    64'd1

`endif

// ==== verilog/csr_pkg.sv ====
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

  // Bit 2 marks the immediate forms
  typedef enum logic [2:0] {
    e_csrr   = 3'b000,
    e_csrrw  = 3'b001,
    e_csrrs  = 3'b010,
    e_csrrc  = 3'b011,
    e_csrrwi = 3'b101,
    e_csrrsi = 3'b110,
    e_csrrci = 3'b111
  } csr_op_e;

  // Same word seen raw or through the mstatus fields
  typedef union packed {
    logic [`CSR_XLEN-1:0] raw;
    struct packed {
      logic [`CSR_XLEN-14:0] pad_hi;
      logic [1:0]            mpp;
      logic [2:0]            pad_mid;
      logic                  mpie;
      logic [2:0]            pad_lo;
      logic                  mie;
      logic [2:0]            pad_lsb;
    } mstatus;
  } csr_word_u;

endpackage

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_regfile (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire [`CSR_XLEN-1:0]   hart_id_i,
  input  wire                   timer_irq_i,
  input  wire                   software_irq_i,
  input  wire                   external_irq_i,
  input  wire                   cmd_v_i,
  input  wire csr_pkg::csr_op_e cmd_op_i,
  input  wire [11:0]            cmd_addr_i,
  input  wire [`CSR_XLEN-1:0]   cmd_operand_i,
  input  wire                   ret_v_i,
  input  wire [`CSR_XLEN-1:0]   ret_pc_i,
  input  wire [`CSR_XLEN-1:0]   ret_tval_i,
  input  wire                   ret_exc_v_i,
  input  wire [3:0]             ret_exc_code_i,
  input  wire                   ret_irq_i,
  input  wire                   ret_mret_i,
  input  wire                   irq_v_i,
  input  wire [3:0]             irq_code_i,
  output logic [`CSR_XLEN-1:0]  mie_o,
  output logic [`CSR_XLEN-1:0]  mip_o,
  output logic                  mstatus_mie_o,
  output logic [1:0]            priv_o,
  output logic                  csr_v_o,
  output logic [`CSR_XLEN-1:0]  csr_data_o,
  output logic                  csr_illegal_o,
  output logic                  commit_v_o,
  output logic                  redirect_o,
  output logic                  trap_o,
  output logic [`CSR_XLEN-1:0]  npc_o
);

  import csr_pkg::*;

  logic [1:0]           priv_r, priv_n;
  csr_word_u            mstatus_r, mstatus_n;
  logic [`CSR_XLEN-1:0] mie_r, mie_n;
  logic [`CSR_XLEN-1:0] mip_r, mip_n;
  logic [`CSR_XLEN-1:0] mtvec_r, mtvec_n;
  logic [`CSR_XLEN-1:0] mscratch_r, mscratch_n;
  logic [`CSR_XLEN-1:0] mepc_r, mepc_n;
  logic [`CSR_XLEN-1:0] mcause_r, mcause_n;
  logic [`CSR_XLEN-1:0] mtval_r, mtval_n;
  logic [`CSR_XLEN-1:0] mcycle_r, mcycle_n;
  logic [`CSR_XLEN-1:0] minstret_r, minstret_n;
  logic [`CSR_XLEN-1:0] mcountinhibit_r, mcountinhibit_n;

  logic [`CSR_XLEN-1:0] rdata;
  logic [`CSR_XLEN-1:0] wdata;
  logic                 known;
  logic                 read_only;
  logic                 illegal;
  logic                 wr_en;
  logic                 take_irq;
  logic                 take_exc;
  logic                 do_mret;
  logic                 trap;

  always_comb
  begin
    known = 1'b1;
    rdata = '0;
    case (cmd_addr_i)
      `CSR_ADDR_MSTATUS:                  rdata = mstatus_r.raw;
      `CSR_ADDR_MISA:                     rdata = `MISA_VALUE;
      `CSR_ADDR_MIE:                      rdata = mie_r;
      `CSR_ADDR_MTVEC:                    rdata = mtvec_r;
      `CSR_ADDR_MCOUNTINHIBIT:            rdata = mcountinhibit_r;
      `CSR_ADDR_MSCRATCH:                 rdata = mscratch_r;
      `CSR_ADDR_MEPC:                     rdata = mepc_r;
      `CSR_ADDR_MCAUSE:                   rdata = mcause_r;
      `CSR_ADDR_MTVAL:                    rdata = mtval_r;
      `CSR_ADDR_MIP:                      rdata = mip_r;
      `CSR_ADDR_MCYCLE, `CSR_ADDR_CYCLE:  rdata = mcycle_r;
      `CSR_ADDR_MINSTRET, `CSR_ADDR_INSTRET:
        rdata = minstret_r;
      `CSR_ADDR_MVENDORID:                rdata = `MVENDORID_VALUE;
      `CSR_ADDR_MARCHID:                  rdata = `MARCHID_VALUE;
      `CSR_ADDR_MIMPID:                   rdata = `MIMPID_VALUE;
      `CSR_ADDR_MHARTID:                  rdata = hart_id_i;
      default:                            known = 1'b0;
    endcase
  end

  // Top address bits 11 mark the read-only space; misa fields are fixed too
  assign read_only = (cmd_addr_i[11:10] == 2'b11) | (cmd_addr_i == `CSR_ADDR_MISA);
  assign illegal   = ~known | (cmd_addr_i[9:8] > priv_r)
                   | ((cmd_op_i != e_csrr) & read_only);
  assign wr_en     = cmd_v_i & ~illegal & (cmd_op_i != e_csrr);

  always_comb
  begin
    case (cmd_op_i)
      e_csrrw, e_csrrwi: wdata = cmd_operand_i;
      e_csrrs, e_csrrsi: wdata = rdata | cmd_operand_i;
      e_csrrc, e_csrrci: wdata = rdata & ~cmd_operand_i;
      default:           wdata = rdata;
    endcase
  end

  // Interrupt beats exception beats mret
  assign take_irq = ret_v_i & ret_irq_i & irq_v_i;
  assign take_exc = ret_v_i & ~take_irq & ret_exc_v_i;
  assign do_mret  = ret_v_i & ~take_irq & ~take_exc & ret_mret_i;
  assign trap     = take_irq | take_exc;

  always_comb
  begin
    priv_n          = priv_r;
    mstatus_n       = mstatus_r;
    mie_n           = mie_r;
    mtvec_n         = mtvec_r;
    mscratch_n      = mscratch_r;
    mepc_n          = mepc_r;
    mcause_n        = mcause_r;
    mtval_n         = mtval_r;
    mcountinhibit_n = mcountinhibit_r;

    mcycle_n   = mcountinhibit_r[`MCOUNTINHIBIT_CY] ? mcycle_r : mcycle_r + 1'b1;
    minstret_n = (ret_v_i & ~trap & ~mcountinhibit_r[`MCOUNTINHIBIT_IR])
               ? minstret_r + 1'b1 : minstret_r;

    mip_n                = '0;
    mip_n[`IRQ_CODE_MSI] = software_irq_i;
    mip_n[`IRQ_CODE_MTI] = timer_irq_i;
    mip_n[`IRQ_CODE_MEI] = external_irq_i;

    if (wr_en)
    begin
      case (cmd_addr_i)
        `CSR_ADDR_MSTATUS:       mstatus_n.raw   = wdata;
        `CSR_ADDR_MIE:           mie_n           = wdata;
        `CSR_ADDR_MTVEC:         mtvec_n         = wdata;
        `CSR_ADDR_MCOUNTINHIBIT: mcountinhibit_n = wdata;
        `CSR_ADDR_MSCRATCH:      mscratch_n      = wdata;
        `CSR_ADDR_MEPC:          mepc_n          = wdata;
        `CSR_ADDR_MCAUSE:        mcause_n        = wdata;
        `CSR_ADDR_MTVAL:         mtval_n         = wdata;
        `CSR_ADDR_MCYCLE:        mcycle_n        = wdata;
        `CSR_ADDR_MINSTRET:      minstret_n      = wdata;
        // mip pending bits follow the interrupt lines only
        default:                 ;
      endcase
    end

    if (trap)
    begin
      priv_n                 = `PRIV_M;
      mstatus_n.mstatus.mpp  = priv_r;
      mstatus_n.mstatus.mpie = mstatus_r.mstatus.mie;
      mstatus_n.mstatus.mie  = 1'b0;
      mepc_n                 = ret_pc_i;
      if (take_irq)
      begin
        mcause_n = {1'b1, {(`CSR_XLEN-5){1'b0}}, irq_code_i};
        mtval_n  = '0;
      end
      else
      begin
        mcause_n = {{(`CSR_XLEN-4){1'b0}}, ret_exc_code_i};
        mtval_n  = ret_tval_i;
      end
    end
    else if (do_mret)
    begin
      // Only M and U exist, anything else in mpp returns to M
      priv_n                 = (mstatus_r.mstatus.mpp == `PRIV_U) ? `PRIV_U : `PRIV_M;
      mstatus_n.mstatus.mpp  = `PRIV_U;
      mstatus_n.mstatus.mpie = 1'b1;
      mstatus_n.mstatus.mie  = mstatus_r.mstatus.mpie;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      priv_r          <= `PRIV_M;
      mstatus_r       <= '0;
      mie_r           <= '0;
      mip_r           <= '0;
      mtvec_r         <= '0;
      mscratch_r      <= '0;
      mepc_r          <= '0;
      mcause_r        <= '0;
      mtval_r         <= '0;
      mcycle_r        <= '0;
      minstret_r      <= '0;
      mcountinhibit_r <= '0;
    end
    else
    begin
      priv_r          <= priv_n;
      mstatus_r       <= mstatus_n;
      mie_r           <= mie_n;
      mip_r           <= mip_n;
      mtvec_r         <= mtvec_n;
      mscratch_r      <= mscratch_n;
      mepc_r          <= mepc_n;
      mcause_r        <= mcause_n;
      mtval_r         <= mtval_n;
      mcycle_r        <= mcycle_n;
      minstret_r      <= minstret_n;
      mcountinhibit_r <= mcountinhibit_n;
    end
  end

  assign mie_o         = mie_r;
  assign mip_o         = mip_r;
  assign mstatus_mie_o = mstatus_r.mstatus.mie;
  assign priv_o        = priv_r;

  assign csr_v_o       = cmd_v_i;
  assign csr_illegal_o = cmd_v_i & illegal;
  assign csr_data_o    = illegal ? '0 : rdata;

  assign commit_v_o = ret_v_i;
  assign redirect_o = trap | do_mret;
  assign trap_o     = trap;

  always_comb
  begin
    if (trap)
      npc_o = {mtvec_r[`CSR_XLEN-1:2], 2'b00};
    else if (do_mret)
      npc_o = mepc_r;
    else
      npc_o = ret_pc_i + 'd4;
  end

  a_priv_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    priv_r inside {`PRIV_M, `PRIV_U});

  a_redirect_commit: assert property (@(posedge clk_i) disable iff (rst_i)
    redirect_o |-> commit_v_o);

endmodule

`default_nettype wire

// ==== verilog/csr_retire_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_retire_stage (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   retire_v_i,
  input  wire [`CSR_XLEN-1:0]   retire_pc_i,
  input  wire [31:0]            retire_instr_i,
  input  wire [`CSR_XLEN-1:0]   retire_vaddr_i,
  input  wire [`EXC_WIDTH-1:0]  retire_exc_i,
  input  wire                   retire_irq_i,
  input  wire                   retire_mret_i,
  output logic                  ret_v_o,
  output logic [`CSR_XLEN-1:0]  ret_pc_o,
  output logic [`CSR_XLEN-1:0]  ret_tval_o,
  output logic                  ret_exc_v_o,
  output logic [3:0]            ret_exc_code_o,
  output logic                  ret_irq_o,
  output logic                  ret_mret_o
);

  logic                 exc_v;
  logic [3:0]           exc_code;
  logic [`CSR_XLEN-1:0] tval;

  assign exc_v = |retire_exc_i;

  // Lowest exception number wins
  always_comb
  begin
    exc_code = '0;
    for (int i = `EXC_WIDTH-1; i >= 0; i--)
    begin
      if (retire_exc_i[i])
        exc_code = 4'(i);
    end
  end

  // Illegal instruction reports the encoding, all others the address
  assign tval = (exc_v && exc_code == `EXC_CODE_ILLEGAL_INSTR)
              ? {{(`CSR_XLEN-32){1'b0}}, retire_instr_i}
              : retire_vaddr_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ret_v_o     <= 1'b0;
      ret_exc_v_o <= 1'b0;
      ret_irq_o   <= 1'b0;
      ret_mret_o  <= 1'b0;
    end
    else
    begin
      ret_v_o     <= retire_v_i;
      ret_exc_v_o <= retire_v_i & exc_v;
      ret_irq_o   <= retire_v_i & retire_irq_i;
      ret_mret_o  <= retire_v_i & retire_mret_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ret_pc_o       <= retire_pc_i;
    ret_tval_o     <= tval;
    ret_exc_code_o <= exc_code;
  end

  a_mret_no_exc: assert property (@(posedge clk_i) disable iff (rst_i)
    (retire_v_i & retire_mret_i) |-> !exc_v);

endmodule

`default_nettype wire

// ==== verilog/csr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "csr_macros.svh"

module csr_top (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire [`CSR_XLEN-1:0]   hart_id_i,
  input  wire                   csr_cmd_v_i,
  input  wire csr_pkg::csr_op_e csr_op_i,
  input  wire [11:0]            csr_addr_i,
  input  wire [`CSR_XLEN-1:0]   csr_wdata_i,
  input  wire                   retire_v_i,
  input  wire [`CSR_XLEN-1:0]   retire_pc_i,
  input  wire [31:0]            retire_instr_i,
  input  wire [`CSR_XLEN-1:0]   retire_vaddr_i,
  input  wire [`EXC_WIDTH-1:0]  retire_exc_i,
  input  wire                   retire_irq_i,
  input  wire                   retire_mret_i,
  input  wire                   timer_irq_i,
  input  wire                   software_irq_i,
  input  wire                   external_irq_i,
  output logic                  csr_v_o,
  output logic [`CSR_XLEN-1:0]  csr_data_o,
  output logic                  csr_illegal_o,
  output logic                  commit_v_o,
  output logic                  redirect_o,
  output logic                  trap_o,
  output logic [`CSR_XLEN-1:0]  npc_o,
  output logic                  irq_pending_o,
  output logic [1:0]            priv_o
);

  import csr_pkg::*;

  logic                 cmd_v;
  csr_op_e              cmd_op;
  logic [11:0]          cmd_addr;
  logic [`CSR_XLEN-1:0] cmd_operand;

  logic                 ret_v;
  logic [`CSR_XLEN-1:0] ret_pc;
  logic [`CSR_XLEN-1:0] ret_tval;
  logic                 ret_exc_v;
  logic [3:0]           ret_exc_code;
  logic                 ret_irq;
  logic                 ret_mret;

  logic [`CSR_XLEN-1:0] mie;
  logic [`CSR_XLEN-1:0] mip;
  logic                 mstatus_mie;
  logic [3:0]           irq_code;

  csr_cmd_stage u_cmd_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .csr_cmd_v_i   (csr_cmd_v_i),
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .cmd_v_o       (cmd_v),
    .cmd_op_o      (cmd_op),
    .cmd_addr_o    (cmd_addr),
    .cmd_operand_o (cmd_operand)
  );

  csr_retire_stage u_retire_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .retire_v_i     (retire_v_i),
    .retire_pc_i    (retire_pc_i),
    .retire_instr_i (retire_instr_i),
    .retire_vaddr_i (retire_vaddr_i),
    .retire_exc_i   (retire_exc_i),
    .retire_irq_i   (retire_irq_i),
    .retire_mret_i  (retire_mret_i),
    .ret_v_o        (ret_v),
    .ret_pc_o       (ret_pc),
    .ret_tval_o     (ret_tval),
    .ret_exc_v_o    (ret_exc_v),
    .ret_exc_code_o (ret_exc_code),
    .ret_irq_o      (ret_irq),
    .ret_mret_o     (ret_mret)
  );

  // Pending output is already qualified by the global enable
  csr_irq_arbiter u_irq_arbiter (
    .mie_i         (mie),
    .mip_i         (mip),
    .mstatus_mie_i (mstatus_mie),
    .priv_i        (priv_o),
    .irq_v_o       (irq_pending_o),
    .irq_code_o    (irq_code)
  );

  csr_regfile u_regfile (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .hart_id_i      (hart_id_i),
    .timer_irq_i    (timer_irq_i),
    .software_irq_i (software_irq_i),
    .external_irq_i (external_irq_i),
    .cmd_v_i        (cmd_v),
    .cmd_op_i       (cmd_op),
    .cmd_addr_i     (cmd_addr),
    .cmd_operand_i  (cmd_operand),
    .ret_v_i        (ret_v),
    .ret_pc_i       (ret_pc),
    .ret_tval_i     (ret_tval),
    .ret_exc_v_i    (ret_exc_v),
    .ret_exc_code_i (ret_exc_code),
    .ret_irq_i      (ret_irq),
    .ret_mret_i     (ret_mret),
    .irq_v_i        (irq_pending_o),
    .irq_code_i     (irq_code),
    .mie_o          (mie),
    .mip_o          (mip),
    .mstatus_mie_o  (mstatus_mie),
    .priv_o         (priv_o),
    .csr_v_o        (csr_v_o),
    .csr_data_o     (csr_data_o),
    .csr_illegal_o  (csr_illegal_o),
    .commit_v_o     (commit_v_o),
    .redirect_o     (redirect_o),
    .trap_o         (trap_o),
    .npc_o          (npc_o)
  );

endmodule

`default_nettype wire
